//--- logic/shader_pkg.sv
package shader_pkg;

	localparam int SHADER_LANES   = 4;
	localparam int GROUPS         = 4;
	localparam int VGPRS          = 8;
	localparam int SGPRS          = 8;
	localparam int REGFILE_STAGES = 2;

	typedef logic [31:0]                 word;
	typedef logic [SHADER_LANES*32-1:0]  lane_vec;     // Lane i at [i*32 +: 32].
	typedef logic [1:0]                  group_id;
	typedef logic [2:0]                  vgpr_num;
	typedef logic [2:0]                  sgpr_num;
	typedef logic [3:0]                  dest_reg;     // Bit 3 selects the SGPR file.
	typedef logic [SHADER_LANES-1:0]     lane_mask;
	typedef logic [15:0]                 pc_t;
	typedef logic signed [7:0]           pc_offset;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_MOV,
		OP_BRANCH,
		OP_SETMASK
	} alu_op;

	typedef enum logic [1:0] {
		SET_GPR,
		SET_MASK,
		SET_PC
	} setup_kind;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} mul_state;

endpackage

//--- logic/shader_wb_if.sv
`timescale 1ns/1ps

interface shader_wb_if;
	import shader_pkg::*;

	logic     valid;
	logic     ready;
	group_id  group;
	dest_reg  dest;
	logic     scalar;
	logic     writeback;    // Result goes to a GPR.
	lane_vec  lanes;
	lane_mask mask;
	logic     mask_update;
	pc_offset pc_add;
	logic     pc_inc;       // Overrides pc_add with +1.
	logic     pc_update;

	modport tx (
		output valid, group, dest, scalar, writeback, lanes,
		       mask, mask_update, pc_add, pc_inc, pc_update,
		input  ready
	);

	modport rx (
		input  valid, group, dest, scalar, writeback, lanes,
		       mask, mask_update, pc_add, pc_inc, pc_update,
		output ready
	);

endinterface

//--- logic/shader_alu.sv
`timescale 1ns/1ps

module shader_alu (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 alu_valid,
	input  shader_pkg::alu_op    alu_op,
	input  shader_pkg::group_id  alu_group,
	input  shader_pkg::dest_reg  alu_dest,
	input  shader_pkg::lane_vec  alu_a,
	input  shader_pkg::lane_vec  alu_b,
	input  shader_pkg::pc_offset alu_offset,
	shader_wb_if.tx              wb
);
	import shader_pkg::*;

	lane_vec  result;
	logic     s1_valid;
	group_id  s1_group;
	dest_reg  s1_dest;
	lane_vec  s1_lanes;
	pc_offset s1_offset;
	logic     s1_writeback;
	logic     s1_setmask;
	logic     s1_branch;

	always_comb begin
		for (int i = 0; i < SHADER_LANES; i++) begin
			case (alu_op)
				OP_ADD:  result[i*32 +: 32] = alu_a[i*32 +: 32] + alu_b[i*32 +: 32];
				OP_SUB:  result[i*32 +: 32] = alu_a[i*32 +: 32] - alu_b[i*32 +: 32];
				OP_AND:  result[i*32 +: 32] = alu_a[i*32 +: 32] & alu_b[i*32 +: 32];
				OP_OR:   result[i*32 +: 32] = alu_a[i*32 +: 32] | alu_b[i*32 +: 32];
				OP_XOR:  result[i*32 +: 32] = alu_a[i*32 +: 32] ^ alu_b[i*32 +: 32];
				default: result[i*32 +: 32] = alu_a[i*32 +: 32];  // MOV, branch, setmask.
			endcase
		end
	end

	assign wb.pc_update = 1'b1;  // Every ALU op retires one instruction.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			wb.valid <= 1'b0;
		end else begin
			s1_valid <= alu_valid;
			wb.valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_group     <= alu_group;
		s1_dest      <= alu_dest;
		s1_lanes     <= result;
		s1_offset    <= alu_offset;
		s1_writeback <= alu_op != OP_BRANCH && alu_op != OP_SETMASK;
		s1_setmask   <= alu_op == OP_SETMASK;
		s1_branch    <= alu_op == OP_BRANCH;

		wb.group       <= s1_group;
		wb.dest        <= s1_dest;
		wb.scalar      <= s1_dest[3];
		wb.writeback   <= s1_writeback;
		wb.lanes       <= s1_lanes;
		wb.mask_update <= s1_setmask;
		wb.pc_add      <= s1_offset;
		wb.pc_inc      <= !s1_branch;
		for (int i = 0; i < SHADER_LANES; i++)
			wb.mask[i] <= |s1_lanes[i*32 +: 32];  // Lane on where operand is nonzero.
	end

endmodule

//--- logic/shader_mul.sv
`timescale 1ns/1ps

module shader_mul (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                mul_valid,
	input  shader_pkg::group_id mul_group,
	input  shader_pkg::dest_reg mul_dest,
	input  shader_pkg::lane_vec mul_a,
	input  shader_pkg::lane_vec mul_b,
	output logic                mul_ready,
	shader_wb_if.tx             wb
);
	import shader_pkg::*;

	mul_state   state;
	logic [4:0] count;
	lane_vec    a_q;
	lane_vec    b_q;
	lane_vec    acc;
	group_id    group_q;
	dest_reg    dest_q;

	assign mul_ready = state == IDLE;

	assign wb.valid       = state == DONE;
	assign wb.group       = group_q;
	assign wb.dest        = dest_q;
	assign wb.scalar      = dest_q[3];
	assign wb.writeback   = 1'b1;
	assign wb.lanes       = acc;
	assign wb.mask        = '0;
	assign wb.mask_update = 1'b0;
	assign wb.pc_add      = '0;
	assign wb.pc_inc      = 1'b1;
	assign wb.pc_update   = 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (mul_valid) begin
						state <= RUN;
						count <= '0;
					end
				end
				RUN: begin
					count <= count + 1'b1;
					if (count == 5'd31)
						state <= DONE;  // 32 steps after acceptance.
				end
				DONE: begin
					if (wb.ready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && mul_valid) begin
			group_q <= mul_group;
			dest_q  <= mul_dest;
			a_q     <= mul_a;
			b_q     <= mul_b;
			acc     <= '0;
		end else if (state == RUN) begin
			for (int i = 0; i < SHADER_LANES; i++) begin
				if (b_q[i*32])
					acc[i*32 +: 32] <= acc[i*32 +: 32] + a_q[i*32 +: 32];
				a_q[i*32 +: 32] <= {a_q[i*32 +: 31], 1'b0};
				b_q[i*32 +: 32] <= {1'b0, b_q[i*32+1 +: 31]};
			end
		end
	end

endmodule

//--- logic/shader_wb_arbiter.sv
`timescale 1ns/1ps

module shader_wb_arbiter (
	input  logic    clk,
	input  logic    rst_n,
	shader_wb_if.rx a,
	shader_wb_if.rx b,
	shader_wb_if.tx out
);

	assign a.ready = out.ready;
	assign b.ready = out.ready & ~a.valid;  // Fixed priority to a.

	assign out.valid = a.valid | b.valid;

	always_comb begin
		if (a.valid) begin
			out.group       = a.group;
			out.dest        = a.dest;
			out.scalar      = a.scalar;
			out.writeback   = a.writeback;
			out.lanes       = a.lanes;
			out.mask        = a.mask;
			out.mask_update = a.mask_update;
			out.pc_add      = a.pc_add;
			out.pc_inc      = a.pc_inc;
			out.pc_update   = a.pc_update;
		end else begin
			out.group       = b.group;
			out.dest        = b.dest;
			out.scalar      = b.scalar;
			out.writeback   = b.writeback;
			out.lanes       = b.lanes;
			out.mask        = b.mask;
			out.mask_update = b.mask_update;
			out.pc_add      = b.pc_add;
			out.pc_inc      = b.pc_inc;
			out.pc_update   = b.pc_update;
		end
	end

	// A losing request must keep its result until granted.
	assert property (@(posedge clk) disable iff (!rst_n)
		(b.valid && !b.ready) |=> (b.valid && $stable(b.lanes)))
	else $error("arbiter: b result dropped or changed while waiting");

endmodule

//--- logic/shader_writeback.sv
`timescale 1ns/1ps

module shader_writeback (
	input  logic                  clk,
	input  logic                  rst_n,
	shader_wb_if.rx               wb,
	output shader_pkg::lane_mask  vgpr_en,
	output shader_pkg::group_id   vgpr_group,
	output shader_pkg::vgpr_num   vgpr_idx,
	output shader_pkg::lane_vec   vgpr_data,
	output logic                  sgpr_we,
	output shader_pkg::group_id   sgpr_group,
	output shader_pkg::sgpr_num   sgpr_idx,
	output shader_pkg::word       sgpr_data,
	output logic                  pc_we,
	output shader_pkg::group_id   pc_wgroup,
	output shader_pkg::pc_t       pc_wdata,
	output logic                  mask_we,
	output shader_pkg::group_id   mask_wgroup,
	output shader_pkg::lane_mask  mask_wdata,
	output shader_pkg::group_id   pc_group,
	input  shader_pkg::pc_t       pc_cur,
	input  shader_pkg::lane_mask  mask_cur,
	input  logic                  setup_req,
	input  shader_pkg::setup_kind setup_kind,
	input  shader_pkg::group_id   setup_group,
	input  shader_pkg::dest_reg   setup_index,
	input  shader_pkg::word       setup_value,
	output logic                  setup_ack,
	output logic                  loop_valid,
	output shader_pkg::group_id   loop_group
);
	import shader_pkg::*;

	logic     st_valid    [REGFILE_STAGES];
	group_id  st_group    [REGFILE_STAGES];
	vgpr_num  st_vgpr     [REGFILE_STAGES];
	lane_vec  st_lanes    [REGFILE_STAGES];
	lane_mask st_mask     [REGFILE_STAGES];
	pc_offset st_pc_add   [REGFILE_STAGES];
	logic     st_vgpr_upd [REGFILE_STAGES];
	logic     st_mask_upd [REGFILE_STAGES];
	logic     st_pc_upd   [REGFILE_STAGES];

	logic    take;
	logic    sc_valid;
	group_id sc_group;
	sgpr_num sc_idx;
	word     sc_data;

	logic res_vgpr, res_mask, res_pc;
	logic gpr_pend, mask_pend, pc_pend;
	logic gpr_fire, mask_fire, pc_fire;
	logic setup_scalar, setup_start;

	assign wb.ready = 1'b1;
	assign take     = wb.valid & wb.ready;

	// Results leaving the delay pipeline this cycle.
	assign res_vgpr = st_valid[REGFILE_STAGES-1] & st_vgpr_upd[REGFILE_STAGES-1];
	assign res_mask = st_valid[REGFILE_STAGES-1] & st_mask_upd[REGFILE_STAGES-1];
	assign res_pc   = st_valid[REGFILE_STAGES-1] & st_pc_upd[REGFILE_STAGES-1];
	assign pc_group = st_group[REGFILE_STAGES-1];

	// Host writes go into slots that no result is using.
	assign setup_scalar = setup_index[3];
	assign gpr_fire     = gpr_pend & (setup_scalar ? ~sc_valid : ~res_vgpr);
	assign mask_fire    = mask_pend & ~res_mask;
	assign pc_fire      = pc_pend & ~res_pc;
	assign setup_start  = setup_req & ~setup_ack & ~(gpr_pend | mask_pend | pc_pend);

	assign vgpr_en    = res_vgpr ? mask_cur :
	                    (gpr_fire & ~setup_scalar) ? '1 : '0;
	assign vgpr_group = res_vgpr ? st_group[REGFILE_STAGES-1] : setup_group;
	assign vgpr_idx   = res_vgpr ? st_vgpr[REGFILE_STAGES-1] : setup_index[2:0];
	assign vgpr_data  = res_vgpr ? st_lanes[REGFILE_STAGES-1] : {SHADER_LANES{setup_value}};

	assign sgpr_we    = sc_valid | (gpr_fire & setup_scalar);
	assign sgpr_group = sc_valid ? sc_group : setup_group;
	assign sgpr_idx   = sc_valid ? sc_idx : setup_index[2:0];
	assign sgpr_data  = sc_valid ? sc_data : setup_value;

	assign pc_we     = res_pc | pc_fire;
	assign pc_wgroup = res_pc ? st_group[REGFILE_STAGES-1] : setup_group;
	assign pc_wdata  = res_pc ? pc_cur + pc_t'(st_pc_add[REGFILE_STAGES-1]) : pc_t'(setup_value);

	assign mask_we     = res_mask | mask_fire;
	assign mask_wgroup = res_mask ? st_group[REGFILE_STAGES-1] : setup_group;
	assign mask_wdata  = res_mask ? st_mask[REGFILE_STAGES-1] : lane_mask'(setup_value);

	assign loop_valid = pc_we;
	assign loop_group = pc_wgroup;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REGFILE_STAGES; i++)
				st_valid[i] <= 1'b0;
			sc_valid  <= 1'b0;
			gpr_pend  <= 1'b0;
			mask_pend <= 1'b0;
			pc_pend   <= 1'b0;
			setup_ack <= 1'b0;
		end else begin
			st_valid[0] <= take;
			for (int i = 1; i < REGFILE_STAGES; i++)
				st_valid[i] <= st_valid[i-1];
			sc_valid <= take & wb.writeback & wb.scalar;

			gpr_pend  <= (gpr_pend & ~gpr_fire) | (setup_start & setup_kind == SET_GPR);
			mask_pend <= (mask_pend & ~mask_fire) | (setup_start & setup_kind == SET_MASK);
			pc_pend   <= (pc_pend & ~pc_fire) | (setup_start & setup_kind == SET_PC);
			setup_ack <= setup_ack ? setup_req : (gpr_fire | mask_fire | pc_fire);
		end
	end

	always_ff @(posedge clk) begin
		st_group[0]    <= wb.group;
		st_vgpr[0]     <= wb.dest[2:0];
		st_lanes[0]    <= wb.lanes;
		st_mask[0]     <= wb.mask;
		st_pc_add[0]   <= wb.pc_inc ? pc_offset'(1) : wb.pc_add;
		st_vgpr_upd[0] <= wb.writeback & ~wb.scalar;
		st_mask_upd[0] <= wb.mask_update;
		st_pc_upd[0]   <= wb.pc_update;
		for (int i = 1; i < REGFILE_STAGES; i++) begin
			st_group[i]    <= st_group[i-1];
			st_vgpr[i]     <= st_vgpr[i-1];
			st_lanes[i]    <= st_lanes[i-1];
			st_mask[i]     <= st_mask[i-1];
			st_pc_add[i]   <= st_pc_add[i-1];
			st_vgpr_upd[i] <= st_vgpr_upd[i-1];
			st_mask_upd[i] <= st_mask_upd[i-1];
			st_pc_upd[i]   <= st_pc_upd[i-1];
		end

		sc_group <= wb.group;
		sc_idx   <= wb.dest[2:0];
		sc_data  <= wb.lanes[31:0];  // Scalar results live in lane 0.
	end

endmodule

//--- logic/shader_regfile.sv
`timescale 1ns/1ps

module shader_regfile (
	input  logic                 clk,
	input  logic                 rst_n,
	input  shader_pkg::lane_mask vgpr_en,
	input  shader_pkg::group_id  vgpr_group,
	input  shader_pkg::vgpr_num  vgpr_idx,
	input  shader_pkg::lane_vec  vgpr_data,
	input  logic                 sgpr_we,
	input  shader_pkg::group_id  sgpr_group,
	input  shader_pkg::sgpr_num  sgpr_idx,
	input  shader_pkg::word      sgpr_data,
	input  logic                 pc_we,
	input  shader_pkg::group_id  pc_wgroup,
	input  shader_pkg::pc_t      pc_wdata,
	input  logic                 mask_we,
	input  shader_pkg::group_id  mask_wgroup,
	input  shader_pkg::lane_mask mask_wdata,
	input  shader_pkg::group_id  pc_group,
	output shader_pkg::pc_t      pc_cur,
	output shader_pkg::lane_mask mask_cur,
	input  shader_pkg::group_id  rd_group,
	input  shader_pkg::vgpr_num  rd_vgpr,
	input  shader_pkg::sgpr_num  rd_sgpr,
	output shader_pkg::lane_vec  rd_vdata,
	output shader_pkg::word      rd_sdata,
	output shader_pkg::pc_t      rd_pc,
	output shader_pkg::lane_mask rd_mask
);
	import shader_pkg::*;

	lane_vec  vgpr_mem [GROUPS][VGPRS];
	word      sgpr_mem [GROUPS][SGPRS];
	pc_t      pc_mem   [GROUPS];
	lane_mask mask_mem [GROUPS];

	assign pc_cur   = pc_mem[pc_group];
	assign mask_cur = mask_mem[pc_group];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int g = 0; g < GROUPS; g++) begin
				for (int r = 0; r < VGPRS; r++)
					vgpr_mem[g][r] <= '0;
				for (int r = 0; r < SGPRS; r++)
					sgpr_mem[g][r] <= '0;
				pc_mem[g]   <= '0;
				mask_mem[g] <= '1;  // All lanes active.
			end
		end else begin
			for (int l = 0; l < SHADER_LANES; l++) begin
				if (vgpr_en[l])
					vgpr_mem[vgpr_group][vgpr_idx][l*32 +: 32] <= vgpr_data[l*32 +: 32];
			end
			if (sgpr_we)
				sgpr_mem[sgpr_group][sgpr_idx] <= sgpr_data;
			if (pc_we)
				pc_mem[pc_wgroup] <= pc_wdata;
			if (mask_we)
				mask_mem[mask_wgroup] <= mask_wdata;
		end
	end

	// Host observation port.
	always_ff @(posedge clk) begin
		rd_vdata <= vgpr_mem[rd_group][rd_vgpr];
		rd_sdata <= sgpr_mem[rd_group][rd_sgpr];
		rd_pc    <= pc_mem[rd_group];
		rd_mask  <= mask_mem[rd_group];
	end

endmodule

//--- logic/shader_back.sv
`timescale 1ns/1ps

module shader_back (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  alu_valid,
	input  shader_pkg::alu_op     alu_op,
	input  shader_pkg::group_id   alu_group,
	input  shader_pkg::dest_reg   alu_dest,
	input  shader_pkg::lane_vec   alu_a,
	input  shader_pkg::lane_vec   alu_b,
	input  shader_pkg::pc_offset  alu_offset,
	input  logic                  mul_valid,
	output logic                  mul_ready,
	input  shader_pkg::group_id   mul_group,
	input  shader_pkg::dest_reg   mul_dest,
	input  shader_pkg::lane_vec   mul_a,
	input  shader_pkg::lane_vec   mul_b,
	input  logic                  setup_req,
	input  shader_pkg::setup_kind setup_kind,
	input  shader_pkg::group_id   setup_group,
	input  shader_pkg::dest_reg   setup_index,
	input  shader_pkg::word       setup_value,
	output logic                  setup_ack,
	output logic                  loop_valid,
	output shader_pkg::group_id   loop_group,
	input  shader_pkg::group_id   rd_group,
	input  shader_pkg::vgpr_num   rd_vgpr,
	input  shader_pkg::sgpr_num   rd_sgpr,
	output shader_pkg::lane_vec   rd_vdata,
	output shader_pkg::word       rd_sdata,
	output shader_pkg::pc_t       rd_pc,
	output shader_pkg::lane_mask  rd_mask
);
	import shader_pkg::*;

	lane_mask vgpr_en;
	group_id  vgpr_group;
	vgpr_num  vgpr_idx;
	lane_vec  vgpr_data;
	logic     sgpr_we;
	group_id  sgpr_group;
	sgpr_num  sgpr_idx;
	word      sgpr_data;
	logic     pc_we;
	group_id  pc_wgroup;
	pc_t      pc_wdata;
	logic     mask_we;
	group_id  mask_wgroup;
	lane_mask mask_wdata;
	group_id  pc_group;
	pc_t      pc_cur;
	lane_mask mask_cur;

	shader_wb_if alu_wb();
	shader_wb_if mul_wb();
	shader_wb_if out_wb();

	shader_alu alu (
		.clk, .rst_n, .alu_valid, .alu_op, .alu_group, .alu_dest,
		.alu_a, .alu_b, .alu_offset,
		.wb(alu_wb.tx)
	);

	shader_mul mul (
		.clk, .rst_n, .mul_valid, .mul_group, .mul_dest, .mul_a, .mul_b,
		.mul_ready,
		.wb(mul_wb.tx)
	);

	shader_wb_arbiter wb_arbiter (
		.clk, .rst_n,
		.a(alu_wb.rx),
		.b(mul_wb.rx),
		.out(out_wb.tx)
	);

	shader_writeback writeback (
		.clk, .rst_n,
		.wb(out_wb.rx),
		.vgpr_en, .vgpr_group, .vgpr_idx, .vgpr_data,
		.sgpr_we, .sgpr_group, .sgpr_idx, .sgpr_data,
		.pc_we, .pc_wgroup, .pc_wdata,
		.mask_we, .mask_wgroup, .mask_wdata,
		.pc_group, .pc_cur, .mask_cur,
		.setup_req, .setup_kind, .setup_group, .setup_index, .setup_value,
		.setup_ack, .loop_valid, .loop_group
	);

	shader_regfile regfile (
		.clk, .rst_n,
		.vgpr_en, .vgpr_group, .vgpr_idx, .vgpr_data,
		.sgpr_we, .sgpr_group, .sgpr_idx, .sgpr_data,
		.pc_we, .pc_wgroup, .pc_wdata,
		.mask_we, .mask_wgroup, .mask_wdata,
		.pc_group, .pc_cur, .mask_cur,
		.rd_group, .rd_vgpr, .rd_sgpr,
		.rd_vdata, .rd_sdata, .rd_pc, .rd_mask
	);

endmodule

//--- verification/shader_back_checker.sv
`timescale 1ns/1ps

module shader_back_checker (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                a_valid,
	input  logic                a_ready,
	input  logic                out_valid,
	input  logic                out_ready,
	input  shader_pkg::lane_vec out_lanes
);

	int failures = 0;

	// The ALU cannot stall, so its result is always granted.
	a_always_granted: assert property (@(posedge clk) disable iff (!rst_n)
		a_valid |-> a_ready)
	else begin
		$error("checker: ALU result offered but not granted");
		failures++;
	end

	out_holds: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_lanes)))
	else begin
		$error("checker: writeback bus dropped or changed data before transfer");
		failures++;
	end

endmodule

//--- verification/shader_back_tb.sv
`timescale 1ns/1ps

module shader_back_tb;
	import shader_pkg::*;

	logic      clk;
	logic      rst_n;
	logic      alu_valid;
	alu_op     op_sel;
	group_id   alu_group;
	dest_reg   alu_dest;
	lane_vec   alu_a;
	lane_vec   alu_b;
	pc_offset  alu_offset;
	logic      mul_valid;
	logic      mul_ready;
	group_id   mul_group;
	dest_reg   mul_dest;
	lane_vec   mul_a;
	lane_vec   mul_b;
	logic      setup_req;
	setup_kind set_kind;
	group_id   setup_group;
	dest_reg   setup_index;
	word       setup_value;
	logic      setup_ack;
	logic      loop_valid;
	group_id   loop_group;
	group_id   rd_group;
	vgpr_num   rd_vgpr;
	sgpr_num   rd_sgpr;
	lane_vec   rd_vdata;
	word       rd_sdata;
	pc_t       rd_pc;
	lane_mask  rd_mask;

	// Reference model of the register file.
	lane_vec  m_vgpr [GROUPS][VGPRS];
	word      m_sgpr [GROUPS][SGPRS];
	pc_t      m_pc   [GROUPS];
	lane_mask m_mask [GROUPS];

	int      errors = 0;
	int      checks = 0;
	int      loop_count = 0;
	group_id last_loop_group;

	shader_back UUT (
		.alu_op(op_sel),
		.setup_kind(set_kind),
		.*
	);

	bind shader_wb_arbiter shader_back_checker wb_check (
		.clk(clk), .rst_n(rst_n),
		.a_valid(a.valid), .a_ready(a.ready),
		.out_valid(out.valid), .out_ready(out.ready), .out_lanes(out.lanes)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk) begin
		if (rst_n && loop_valid) begin
			loop_count++;  // Counts PC writes seen by the front end.
			last_loop_group = loop_group;
		end
	end

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic check_word(string name, word exp, word act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_lanes(string name, lane_vec exp, lane_vec act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_mask(string name, lane_mask exp, lane_mask act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_pc(string name, pc_t exp, pc_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_group(string name, group_id exp, group_id act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	function automatic word lane_result(alu_op op, word a, word b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			default: return a;
		endcase
	endfunction

	function automatic void model_alu(alu_op op, group_id g, dest_reg dest,
	                                  lane_vec a, lane_vec b, pc_offset off);
		if (op == OP_BRANCH) begin
			m_pc[g] = m_pc[g] + {{8{off[7]}}, off};
		end else begin
			m_pc[g] = m_pc[g] + 1'b1;
			if (op == OP_SETMASK) begin
				for (int l = 0; l < SHADER_LANES; l++)
					m_mask[g][l] = a[l*32 +: 32] != 0;
			end else if (dest[3]) begin
				m_sgpr[g][dest[2:0]] = lane_result(op, a[31:0], b[31:0]);
			end else begin
				for (int l = 0; l < SHADER_LANES; l++)
					if (m_mask[g][l])
						m_vgpr[g][dest[2:0]][l*32 +: 32] =
							lane_result(op, a[l*32 +: 32], b[l*32 +: 32]);
			end
		end
	endfunction

	function automatic void model_mul(group_id g, dest_reg dest, lane_vec a, lane_vec b);
		word p;
		m_pc[g] = m_pc[g] + 1'b1;
		for (int l = 0; l < SHADER_LANES; l++) begin
			p = a[l*32 +: 32] * b[l*32 +: 32];  // Low half of the product.
			if (dest[3] && l == 0)
				m_sgpr[g][dest[2:0]] = p;
			else if (!dest[3] && m_mask[g][l])
				m_vgpr[g][dest[2:0]][l*32 +: 32] = p;
		end
	endfunction

	function automatic lane_vec rand_lanes();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic wait_loops(int target, string name);
		int n;
		n = 0;
		while (loop_count < target && n < 200) begin
			step();
			n++;
		end
		if (loop_count < target) begin
			errors++;
			$display("Timeout in %s: loop notification never arrived", name);
		end
	endtask

	task automatic wait_ack(logic level, string name);
		int n;
		n = 0;
		while (setup_ack !== level && n < 50) begin
			step();
			n++;
		end
		if (setup_ack !== level) begin
			errors++;
			$display("Timeout in %s: setup_ack did not reach %b", name, level);
		end
	endtask

	task automatic wait_mul_ready(string name);
		int n;
		n = 0;
		while (mul_ready !== 1'b1 && n < 100) begin
			step();
			n++;
		end
		if (mul_ready !== 1'b1) begin
			errors++;
			$display("Timeout in %s: multiplier never became ready", name);
		end
	endtask

	task automatic read_check(group_id g, vgpr_num v, sgpr_num s, string name);
		rd_group = g;
		rd_vgpr  = v;
		rd_sgpr  = s;
		step();  // Registered read port.
		check_lanes({name, " vgpr"}, m_vgpr[g][v], rd_vdata);
		check_word({name, " sgpr"}, m_sgpr[g][s], rd_sdata);
		check_pc({name, " pc"}, m_pc[g], rd_pc);
		check_mask({name, " mask"}, m_mask[g], rd_mask);
	endtask

	task automatic issue_alu(alu_op op, group_id g, dest_reg dest,
	                         lane_vec a, lane_vec b, pc_offset off);
		alu_valid  = 1'b1;
		op_sel     = op;
		alu_group  = g;
		alu_dest   = dest;
		alu_a      = a;
		alu_b      = b;
		alu_offset = off;
		step();
		alu_valid = 1'b0;
		model_alu(op, g, dest, a, b, off);
	endtask

	task automatic issue_mul(group_id g, dest_reg dest, lane_vec a, lane_vec b);
		mul_valid = 1'b1;
		mul_group = g;
		mul_dest  = dest;
		mul_a     = a;
		mul_b     = b;
		step();
		mul_valid = 1'b0;
		model_mul(g, dest, a, b);
	endtask

	task automatic alu_single(alu_op op, group_id g, dest_reg dest, lane_vec a,
	                          lane_vec b, pc_offset off, string name);
		int c0;
		c0 = loop_count;
		issue_alu(op, g, dest, a, b, off);
		wait_loops(c0 + 1, name);
		check_group({name, " loop group"}, g, last_loop_group);
		read_check(g, dest[2:0], dest[2:0], name);
	endtask

	task automatic do_setup(setup_kind kind, group_id g, dest_reg idx, word value,
	                        string name);
		int c0;
		c0 = loop_count;
		setup_req   = 1'b1;
		set_kind    = kind;
		setup_group = g;
		setup_index = idx;
		setup_value = value;
		wait_ack(1'b1, name);
		check_flag({name, " loop pulse"}, kind == SET_PC, loop_count == c0 + 1);
		if (kind == SET_PC)
			check_group({name, " loop group"}, g, last_loop_group);
		setup_req = 1'b0;
		wait_ack(1'b0, name);
		case (kind)
			SET_GPR: begin
				if (idx[3])
					m_sgpr[g][idx[2:0]] = value;
				else
					m_vgpr[g][idx[2:0]] = {SHADER_LANES{value}};  // All lanes.
			end
			SET_MASK: m_mask[g] = value[SHADER_LANES-1:0];
			default:  m_pc[g] = value[15:0];
		endcase
		read_check(g, idx[2:0], idx[2:0], name);
	endtask

	task automatic test_setup();
		do_setup(SET_GPR, 2'd3, 4'd2, $urandom, "setup vgpr");
		do_setup(SET_GPR, 2'd3, 4'b1101, $urandom, "setup sgpr");
		do_setup(SET_MASK, 2'd3, 4'd0, 32'h0000_000b, "setup mask");
		do_setup(SET_PC, 2'd3, 4'd0, 32'h0000_0100, "setup pc");
	endtask

	task automatic test_alu();
		dest_reg dest;
		for (int i = 0; i <= 5; i++) begin
			dest = {i[0], i[2:0]};  // Odd ops go to the SGPR file.
			alu_single(alu_op'(i), 2'd0, dest, rand_lanes(), rand_lanes(), '0,
			           $sformatf("alu op %0d", i));
		end
	endtask

	task automatic test_mask();
		lane_vec a;
		do_setup(SET_GPR, 2'd1, 4'd5, 32'hdead_beef, "mask preset");
		a = {32'h0, $urandom | 32'h1, 32'h0, $urandom | 32'h1};
		alu_single(OP_SETMASK, 2'd1, 4'd0, a, '0, '0, "setmask");
		check_mask("setmask lanes", 4'b0101, rd_mask);
		alu_single(OP_ADD, 2'd1, 4'd5, rand_lanes(), rand_lanes(), '0, "masked add");
		check_word("masked lane 1", 32'hdead_beef, rd_vdata[63:32]);
		check_word("masked lane 3", 32'hdead_beef, rd_vdata[127:96]);
		alu_single(OP_SETMASK, 2'd1, 4'd0, {4{32'h1}}, '0, '0, "mask restore");
	endtask

	task automatic test_branch();
		alu_single(OP_BRANCH, 2'd0, 4'd1, rand_lanes(), rand_lanes(), 8'sd5, "branch fwd");
		alu_single(OP_BRANCH, 2'd0, 4'd1, rand_lanes(), rand_lanes(), -8'sd3, "branch back");
	endtask

	task automatic test_mul();
		int c0;
		dest_reg dest;
		for (int i = 0; i < 3; i++) begin
			dest = (i == 2) ? 4'b1110 : dest_reg'(i);
			wait_mul_ready("mul issue");
			c0 = loop_count;
			issue_mul(2'd2, dest, rand_lanes(), rand_lanes());
			check_flag("mul busy", 1'b0, mul_ready);
			wait_loops(c0 + 1, "mul result");
			check_flag("mul ready again", 1'b1, mul_ready);
			read_check(2'd2, dest[2:0], dest[2:0], $sformatf("mul %0d", i));
		end
	endtask

	task automatic test_contention();
		int c0;
		wait_mul_ready("contention issue");
		c0 = loop_count;
		issue_mul(2'd2, 4'd3, rand_lanes(), rand_lanes());
		repeat (24) step();
		// Twelve ALU results cover the cycle where the product is ready.
		for (int i = 0; i < 12; i++)
			issue_alu(alu_op'($urandom_range(0, 4)), 2'd1, dest_reg'(i),
			          rand_lanes(), rand_lanes(), '0);
		check_flag("contention mul held", 1'b0, mul_ready);
		wait_loops(c0 + 13, "contention");
		check_flag("contention mul ready", 1'b1, mul_ready);
		for (int r = 0; r < 8; r++)
			read_check(2'd1, vgpr_num'(r), sgpr_num'(r), $sformatf("contention alu %0d", r));
		read_check(2'd2, 3'd3, 3'd3, "contention mul");
	endtask

	initial begin
		void'($urandom(32'h150b_40b9));
		rst_n       = 1'b0;
		alu_valid   = 1'b0;
		op_sel      = OP_ADD;
		alu_group   = '0;
		alu_dest    = '0;
		alu_a       = '0;
		alu_b       = '0;
		alu_offset  = '0;
		mul_valid   = 1'b0;
		mul_group   = '0;
		mul_dest    = '0;
		mul_a       = '0;
		mul_b       = '0;
		setup_req   = 1'b0;
		set_kind    = SET_GPR;
		setup_group = '0;
		setup_index = '0;
		setup_value = '0;
		rd_group    = '0;
		rd_vgpr     = '0;
		rd_sgpr     = '0;
		for (int g = 0; g < GROUPS; g++) begin
			for (int r = 0; r < VGPRS; r++)
				m_vgpr[g][r] = '0;
			for (int r = 0; r < SGPRS; r++)
				m_sgpr[g][r] = '0;
			m_pc[g]   = '0;
			m_mask[g] = '1;
		end

		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_flag("reset mul_ready", 1'b1, mul_ready);
		check_flag("reset setup_ack", 1'b0, setup_ack);
		check_flag("reset loop_valid", 1'b0, loop_valid);

		test_setup();
		test_alu();
		test_mask();
		test_branch();
		test_mul();
		test_contention();

		errors += UUT.wb_arbiter.wb_check.failures;  // Bound assertion failures.
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- files.f
logic/shader_pkg.sv
logic/shader_wb_if.sv
logic/shader_alu.sv
logic/shader_mul.sv
logic/shader_wb_arbiter.sv
logic/shader_writeback.sv
logic/shader_regfile.sv
logic/shader_back.sv
verification/shader_back_checker.sv
verification/shader_back_tb.sv
